/* design/osd_defines.svh */
`ifndef OSD_DEFINES_SVH
`define OSD_DEFINES_SVH

// Status word from the HPS
`define OSD_STATUS_W        64

// Only a full HD output can take the 216-line crop
`define OSD_HDMI_W          1920
`define OSD_HDMI_H          1080
`define OSD_CROP_LINES      216

// Menu feature switches, 1 enables the option
`define OSD_ROTATE_MENU     1
`define OSD_60HZ_MENU       1

// Status bit positions (lowest bit of each field)
`define OSD_BIT_SCAN_FX     3
`define OSD_BIT_60HZ        19
`define OSD_BIT_DB15        37
`define OSD_BIT_UART        38
`define OSD_BIT_FB_FLIP     38
`define OSD_BIT_CROP_EN     41
`define OSD_BIT_VCOPT       42
`define OSD_BIT_CROP_SCALE  46
`define OSD_BIT_HSIZE_EN    48
`define OSD_BIT_HSIZE_SCALE 49
`define OSD_BIT_HOFFSET     53
`define OSD_BIT_VOFFSET     57

`endif

/* design/osd_pkg.sv */
`include "osd_defines.svh"

package osd_pkg;

    // OSD status word as sent by the HPS
    typedef logic [`OSD_STATUS_W-1:0] status_t;

    // Vertical crop
    typedef logic [3:0]  vcopt_t;
    // 0 normal, 1 V-integer, 2 HV-integer-, 3 HV-integer+, 4 HV-integer
    typedef logic [2:0]  crop_scale_t;
    // Two's complement, -16 to +15 lines
    typedef logic [4:0]  crop_off_t;
    typedef logic [11:0] crop_size_t;
    typedef logic [11:0] hdmi_dim_t;

    // High bit hides the menu item
    typedef logic [15:0] menumask_t;

    // Pins of the user port
    typedef logic [6:0]  user_port_t;

    // Mouse
    typedef logic [8:0]  mouse_delta_t;
    typedef logic [7:0]  mouse_flags_t;
    // Bit 24 toggles on every new packet
    typedef logic [24:0] ps2_mouse_t;

    // CRT position and horizontal scale
    typedef logic [3:0]  pos_offset_t;

endpackage

/* design/osd_cfg_if.sv */
`timescale 1ns/1ns

interface osd_cfg_if;
    import osd_pkg::*;

    // Crop settings
    logic        crop_en;
    vcopt_t      vcopt;
    crop_scale_t crop_scale;
    logic        scan_fx_off;
    logic        status_60hz;

    // CRT geometry
    logic        hsize_enable;
    pos_offset_t hsize_scale;
    pos_offset_t hoffset;
    pos_offset_t voffset;

    // User port and rotation
    logic        uart_en;
    logic        db15_en;
    logic        framebuf_flip;

    modport producer (
        output crop_en, vcopt, crop_scale, scan_fx_off, status_60hz,
        output hsize_enable, hsize_scale, hoffset, voffset,
        output uart_en, db15_en, framebuf_flip
    );

    modport consumer (
        input crop_en, vcopt, crop_scale, scan_fx_off, status_60hz,
        input hsize_enable, hsize_scale, hoffset, voffset,
        input uart_en, db15_en, framebuf_flip
    );

endinterface

/* design/status_decode.sv */
`timescale 1ns/1ns
`include "osd_defines.svh"

module status_decode (
    input  logic             clk_sys,
    input  logic             rst,
    input  osd_pkg::status_t status,
    osd_cfg_if.producer      cfg
);
    import osd_pkg::*;

    // Enables that switch outputs or pins
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            cfg.crop_en      <= 1'b0;
            cfg.hsize_enable <= 1'b0;
            cfg.uart_en      <= 1'b0;
            cfg.db15_en      <= 1'b0;
        end else begin
            cfg.crop_en      <= status[`OSD_BIT_CROP_EN];
            cfg.hsize_enable <= status[`OSD_BIT_HSIZE_EN];
            cfg.uart_en      <= status[`OSD_BIT_UART];
            cfg.db15_en      <= status[`OSD_BIT_DB15];
        end
    end

    // Plain setting fields
    always_ff @(posedge clk_sys) begin
        cfg.vcopt       <= vcopt_t'(status[`OSD_BIT_VCOPT +: 4]);
        // Only two scale bits in the menu
        cfg.crop_scale  <= crop_scale_t'({1'b0, status[`OSD_BIT_CROP_SCALE +: 2]});
        cfg.status_60hz <= status[`OSD_BIT_60HZ];
        cfg.hsize_scale <= pos_offset_t'(status[`OSD_BIT_HSIZE_SCALE +: 4]);
        cfg.hoffset     <= pos_offset_t'(status[`OSD_BIT_HOFFSET +: 4]);
        cfg.voffset     <= pos_offset_t'(status[`OSD_BIT_VOFFSET +: 4]);
    end

    // Conditions tested once here
    always_ff @(posedge clk_sys) begin
        // No scan line effect selected
        cfg.scan_fx_off   <= status[`OSD_BIT_SCAN_FX +: 3] == 3'd0;
        // Field value 2 selects the flipped framebuffer
        cfg.framebuf_flip <= status[`OSD_BIT_FB_FLIP +: 2] == 2'd2;
    end

endmodule

/* design/crop_calc.sv */
`timescale 1ns/1ns
`include "osd_defines.svh"

module crop_calc (
    input  logic                clk_sys,
    input  logic                rst,
    input  osd_pkg::hdmi_dim_t  hdmi_width,
    input  osd_pkg::hdmi_dim_t  hdmi_height,
    input  logic                force_scan2x,
    input  logic                direct_video,
    input  logic                rotate_en,
    osd_cfg_if.consumer         cfg,
    output logic                crop_ok,
    output osd_pkg::crop_off_t  crop_off,
    output osd_pkg::crop_size_t crop_size
);
    import osd_pkg::*;

    logic      full_hd;
    logic      video_plain;
    crop_off_t off_next;

    assign full_hd = (hdmi_width == hdmi_dim_t'(`OSD_HDMI_W)) &&
                     (hdmi_height == hdmi_dim_t'(`OSD_HDMI_H));

    // Any scaler, effect or bypass rules the crop out
    assign video_plain = cfg.scan_fx_off && (cfg.crop_scale == '0) &&
                         !force_scan2x && !direct_video && !rotate_en;

    // Two lines per vcopt step, upper half maps to negative offsets
    always_comb begin
        if (cfg.vcopt < vcopt_t'(6)) begin
            off_next = crop_off_t'({cfg.vcopt, 1'b0});
        end else begin
            off_next = crop_off_t'({cfg.vcopt, 1'b0} - 5'd24);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            crop_ok   <= 1'b0;
            crop_size <= '0;
        end else begin
            crop_ok <= full_hd && video_plain;
            // Follows the crop_ok of the previous cycle
            if (crop_ok && cfg.crop_en) begin
                crop_size <= crop_size_t'(`OSD_CROP_LINES);
            end else begin
                crop_size <= '0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        crop_off <= off_next;
    end

endmodule

/* design/mouse_decode.sv */
`timescale 1ns/1ns

module mouse_decode (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  osd_pkg::ps2_mouse_t   ps2_mouse,
    input  logic                  mouse_ready,
    output logic                  mouse_valid,
    output osd_pkg::mouse_delta_t mouse_dx,
    output osd_pkg::mouse_delta_t mouse_dy,
    output osd_pkg::mouse_flags_t mouse_flags,
    output logic                  mouse_overrun
);
    import osd_pkg::*;

    logic         toggle_l;
    logic         new_pkt;
    logic         slot_free;
    mouse_flags_t pkt_flags;

    // A toggle on bit 24 marks a fresh packet
    assign new_pkt   = ps2_mouse[24] ^ toggle_l;
    assign pkt_flags = mouse_flags_t'(ps2_mouse[7:0]);

    // Empty now, or emptied by the handshake on this edge
    assign slot_free = !mouse_valid || mouse_ready;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            // Track the bit in reset so no packet shows up on release
            toggle_l      <= ps2_mouse[24];
            mouse_valid   <= 1'b0;
            mouse_overrun <= 1'b0;
        end else begin
            toggle_l <= ps2_mouse[24];
            if (new_pkt && slot_free) begin
                mouse_valid <= 1'b1;
            end else if (mouse_valid && mouse_ready) begin
                mouse_valid <= 1'b0;
            end
            // Sticky until reset
            if (new_pkt && !slot_free) begin
                mouse_overrun <= 1'b1;
            end
        end
    end

    // Holding register, loaded only when the slot is free
    always_ff @(posedge clk_sys) begin
        if (new_pkt && slot_free) begin
            mouse_flags <= pkt_flags;
            // Sign bits live in the flag byte
            mouse_dx    <= mouse_delta_t'({pkt_flags[4], ps2_mouse[15:8]});
            mouse_dy    <= mouse_delta_t'({pkt_flags[5], ps2_mouse[23:16]});
        end
    end

endmodule

/* design/user_osd_outputs.sv */
`timescale 1ns/1ns
`include "osd_defines.svh"

module user_osd_outputs (
    input  logic                clk_sys,
    input  logic                rst,
    input  logic                crop_ok,
    input  logic                core_vertical,
    input  logic                direct_video,
    input  osd_pkg::user_port_t joy_out,
    input  logic                uart_tx,
    input  logic                game_tx,
    input  osd_pkg::user_port_t user_in,
    osd_cfg_if.consumer         cfg,
    output osd_pkg::menumask_t  menumask,
    output osd_pkg::user_port_t user_out,
    output logic                uart_rx,
    output logic                game_rx
);
    import osd_pkg::*;

    menumask_t mask_next;

    // Menu items to hide
    always_comb begin
        mask_next    = '0;
        mask_next[5] = crop_ok;
        // Rotate menu only for vertical games
        mask_next[4] = (`OSD_ROTATE_MENU != 0) ? !core_vertical : 1'b1;
        mask_next[3] = (`OSD_60HZ_MENU != 0) ? cfg.status_60hz : 1'b1;
        mask_next[2] = !cfg.hsize_enable;
        mask_next[1] = (`OSD_ROTATE_MENU != 0) ? 1'b1 : !core_vertical;
        mask_next[0] = direct_video;
    end

    always_ff @(posedge clk_sys) begin
        menumask <= mask_next;
    end

    // DB15 joystick wins over the UART, idle pins stay high
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            user_out <= '1;
        end else if (cfg.db15_en) begin
            user_out <= joy_out;
        end else if (cfg.uart_en) begin
            // Both transmitters share pin 0
            user_out <= {6'h3f, uart_tx & game_tx};
        end else begin
            user_out <= '1;
        end
    end

    // Receive line idles high when the UART is off
    assign uart_rx = cfg.uart_en ? user_in[1] : 1'b1;
    assign game_rx = uart_rx;

endmodule

/* design/osd_ctrl_top.sv */
`timescale 1ns/1ns

module osd_ctrl_top (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  osd_pkg::status_t      status,
    input  osd_pkg::hdmi_dim_t    hdmi_width,
    input  osd_pkg::hdmi_dim_t    hdmi_height,
    input  logic                  force_scan2x,
    input  logic                  direct_video,
    input  logic                  rotate_en,
    input  logic                  core_vertical,
    input  logic                  game_tx,
    input  logic                  uart_tx,
    input  osd_pkg::user_port_t   user_in,
    input  osd_pkg::user_port_t   joy_out,
    input  osd_pkg::ps2_mouse_t   ps2_mouse,
    input  logic                  mouse_ready,
    output osd_pkg::crop_off_t    crop_off,
    output osd_pkg::crop_size_t   crop_size,
    output osd_pkg::crop_scale_t  crop_scale,
    output osd_pkg::menumask_t    menumask,
    output osd_pkg::user_port_t   user_out,
    output logic                  uart_rx,
    output logic                  game_rx,
    output logic                  db15_en,
    output logic                  uart_en,
    output logic                  hsize_enable,
    output osd_pkg::pos_offset_t  hsize_scale,
    output osd_pkg::pos_offset_t  hoffset,
    output osd_pkg::pos_offset_t  voffset,
    output logic                  framebuf_flip,
    output logic                  mouse_valid,
    output osd_pkg::mouse_delta_t mouse_dx,
    output osd_pkg::mouse_delta_t mouse_dy,
    output osd_pkg::mouse_flags_t mouse_flags,
    output logic                  mouse_overrun
);

    logic crop_ok;

    osd_cfg_if cfg_bus ();

    status_decode u_status_decode (
        .clk_sys ( clk_sys ),
        .rst     ( rst     ),
        .status  ( status  ),
        .cfg     ( cfg_bus )
    );

    crop_calc u_crop_calc (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .hdmi_width   ( hdmi_width   ),
        .hdmi_height  ( hdmi_height  ),
        .force_scan2x ( force_scan2x ),
        .direct_video ( direct_video ),
        .rotate_en    ( rotate_en    ),
        .cfg          ( cfg_bus      ),
        .crop_ok      ( crop_ok      ),
        .crop_off     ( crop_off     ),
        .crop_size    ( crop_size    )
    );

    mouse_decode u_mouse_decode (
        .clk_sys       ( clk_sys       ),
        .rst           ( rst           ),
        .ps2_mouse     ( ps2_mouse     ),
        .mouse_ready   ( mouse_ready   ),
        .mouse_valid   ( mouse_valid   ),
        .mouse_dx      ( mouse_dx      ),
        .mouse_dy      ( mouse_dy      ),
        .mouse_flags   ( mouse_flags   ),
        .mouse_overrun ( mouse_overrun )
    );

    user_osd_outputs u_user_osd_outputs (
        .clk_sys       ( clk_sys       ),
        .rst           ( rst           ),
        .crop_ok       ( crop_ok       ),
        .core_vertical ( core_vertical ),
        .direct_video  ( direct_video  ),
        .joy_out       ( joy_out       ),
        .uart_tx       ( uart_tx       ),
        .game_tx       ( game_tx       ),
        .user_in       ( user_in       ),
        .cfg           ( cfg_bus       ),
        .menumask      ( menumask      ),
        .user_out      ( user_out      ),
        .uart_rx       ( uart_rx       ),
        .game_rx       ( game_rx       )
    );

    // Settings for the downstream scaler and rotation
    assign crop_scale    = cfg_bus.crop_scale;
    assign db15_en       = cfg_bus.db15_en;
    assign uart_en       = cfg_bus.uart_en;
    assign hsize_enable  = cfg_bus.hsize_enable;
    assign hsize_scale   = cfg_bus.hsize_scale;
    assign hoffset       = cfg_bus.hoffset;
    assign voffset       = cfg_bus.voffset;
    assign framebuf_flip = cfg_bus.framebuf_flip;

endmodule

/* test/osd_ctrl_assert.sv */
`timescale 1ns/1ns
`include "osd_defines.svh"

module osd_ctrl_assert (
    input logic                  clk_sys,
    input logic                  rst,
    input osd_pkg::status_t      status,
    input osd_pkg::hdmi_dim_t    hdmi_width,
    input osd_pkg::hdmi_dim_t    hdmi_height,
    input logic                  force_scan2x,
    input logic                  direct_video,
    input logic                  rotate_en,
    input logic                  core_vertical,
    input logic                  game_tx,
    input logic                  uart_tx,
    input osd_pkg::user_port_t   user_in,
    input osd_pkg::user_port_t   joy_out,
    input osd_pkg::ps2_mouse_t   ps2_mouse,
    input logic                  mouse_ready,
    input osd_pkg::crop_off_t    crop_off,
    input osd_pkg::crop_size_t   crop_size,
    input osd_pkg::crop_scale_t  crop_scale,
    input osd_pkg::menumask_t    menumask,
    input osd_pkg::user_port_t   user_out,
    input logic                  uart_rx,
    input logic                  game_rx,
    input logic                  db15_en,
    input logic                  uart_en,
    input logic                  hsize_enable,
    input osd_pkg::pos_offset_t  hsize_scale,
    input osd_pkg::pos_offset_t  hoffset,
    input osd_pkg::pos_offset_t  voffset,
    input logic                  framebuf_flip,
    input logic                  mouse_valid,
    input osd_pkg::mouse_delta_t mouse_dx,
    input osd_pkg::mouse_delta_t mouse_dy,
    input osd_pkg::mouse_flags_t mouse_flags,
    input logic                  mouse_overrun
);
    import osd_pkg::*;

    int           err_count = 0;
    logic [107:0] cur_in;
    logic [107:0] prev_in;
    logic         in_stable;
    logic [2:0]   hold_cnt;
    logic         tog_l;
    logic         new_pkt;
    logic         exp_ok;
    logic [4:0]   off_dbl;
    crop_off_t    exp_off;
    crop_size_t   exp_size;
    menumask_t    exp_mask;
    user_port_t   exp_user;
    logic         exp_rx;
    mouse_delta_t exp_dx;
    mouse_delta_t exp_dy;
    logic [17:0]  exp_cfg;
    logic [17:0]  got_cfg;

    assign cur_in = {status, hdmi_width, hdmi_height, force_scan2x, direct_video, rotate_en,
                     core_vertical, game_tx, uart_tx, user_in, joy_out};

    // Inputs unchanged since the previous edge
    assign in_stable = cur_in == prev_in;

    // Edges since the last change of the settings inputs
    always_ff @(posedge clk_sys) begin
        prev_in <= cur_in;
        tog_l   <= ps2_mouse[24];
        if (rst || cur_in != prev_in) begin
            hold_cnt <= 3'd0;
        end else if (hold_cnt != 3'd7) begin
            hold_cnt <= hold_cnt + 3'd1;
        end
    end

    // Expected values from the crop, menu and port rules
    assign exp_ok = hdmi_width == 12'd1920 && hdmi_height == 12'd1080 &&
                    status[5:3] == 3'd0 && status[47:46] == 2'd0 &&
                    !force_scan2x && !direct_video && !rotate_en;
    assign off_dbl  = {status[45:42], 1'b0};
    assign exp_off  = (status[45:42] < 4'd6) ? off_dbl : off_dbl - 5'd24;
    assign exp_size = (exp_ok && status[41]) ? 12'd216 : 12'd0;
    assign exp_mask = {10'd0, exp_ok,
                       (`OSD_ROTATE_MENU != 0) ? !core_vertical : 1'b1,
                       (`OSD_60HZ_MENU != 0) ? status[19] : 1'b1,
                       !status[48],
                       (`OSD_ROTATE_MENU != 0) ? 1'b1 : !core_vertical,
                       direct_video};
    assign exp_user = status[37] ? joy_out :
                      status[38] ? {6'h3f, uart_tx & game_tx} : 7'h7f;
    assign exp_rx   = status[38] ? user_in[1] : 1'b1;
    assign new_pkt  = ps2_mouse[24] != tog_l;
    assign exp_dx   = {ps2_mouse[4], ps2_mouse[15:8]};
    assign exp_dy   = {ps2_mouse[5], ps2_mouse[23:16]};

    // Settings passed on to the downstream scaler
    assign exp_cfg = {1'b0, status[47:46], status[37], status[48], status[52:49],
                      status[56:53], status[60:57], status[39:38] == 2'd2};
    assign got_cfg = {crop_scale, db15_en, hsize_enable, hsize_scale, hoffset, voffset,
                      framebuf_flip};

    a_reset: assert property (@(posedge clk_sys) rst |=> !mouse_valid && !mouse_overrun &&
        !uart_en && crop_size == 12'd0 && user_out == 7'h7f)
        else begin err_count++; $error("Reset values wrong after reset"); end
    a_crop_size: assert property (@(posedge clk_sys) disable iff (rst)
        in_stable && hold_cnt >= 3'd2 |-> crop_size == exp_size)
        else begin err_count++;
            $error("FAILED crop_size expected %h got %h", $sampled(exp_size), $sampled(crop_size));
        end
    a_crop_off: assert property (@(posedge clk_sys) disable iff (rst)
        in_stable && hold_cnt >= 3'd2 |-> crop_off == exp_off)
        else begin err_count++;
            $error("FAILED crop_off expected %h got %h", $sampled(exp_off), $sampled(crop_off));
        end
    a_menumask: assert property (@(posedge clk_sys) disable iff (rst)
        in_stable && hold_cnt >= 3'd2 |-> menumask == exp_mask)
        else begin err_count++;
            $error("FAILED menumask expected %h got %h", $sampled(exp_mask), $sampled(menumask));
        end
    a_user_out: assert property (@(posedge clk_sys) disable iff (rst)
        in_stable && hold_cnt >= 3'd1 |->
        user_out == exp_user && uart_rx == exp_rx && game_rx == exp_rx)
        else begin err_count++;
            $error("FAILED user_out expected %h got %h, uart_rx/game_rx expected %h got %h/%h",
                   $sampled(exp_user), $sampled(user_out), $sampled(exp_rx),
                   $sampled(uart_rx), $sampled(game_rx));
        end
    a_settings: assert property (@(posedge clk_sys) disable iff (rst)
        in_stable && hold_cnt >= 3'd1 |-> got_cfg == exp_cfg)
        else begin err_count++;
            $error("FAILED crop_scale to framebuf_flip expected %h got %h",
                   $sampled(exp_cfg), $sampled(got_cfg));
        end
    a_mouse_load: assert property (@(posedge clk_sys) disable iff (rst)
        new_pkt && (!mouse_valid || mouse_ready) |=>
        mouse_valid && mouse_dx == $past(exp_dx) && mouse_dy == $past(exp_dy) &&
        mouse_flags == $past(ps2_mouse[7:0]))
        else begin err_count++;
            $error("FAILED mouse_dx/mouse_dy/mouse_flags got %h %h %h with valid %h",
                   $sampled(mouse_dx), $sampled(mouse_dy), $sampled(mouse_flags),
                   $sampled(mouse_valid));
        end
    a_mouse_hold: assert property (@(posedge clk_sys) disable iff (rst)
        mouse_valid && !mouse_ready |=> mouse_valid && $stable(mouse_dx) &&
        $stable(mouse_dy) && $stable(mouse_flags))
        else begin err_count++; $error("Held mouse packet changed under back-pressure"); end
    a_mouse_leave: assert property (@(posedge clk_sys) disable iff (rst)
        mouse_valid && mouse_ready && !new_pkt |=> !mouse_valid)
        else begin err_count++; $error("Mouse packet still valid after the handshake"); end
    a_overrun: assert property (@(posedge clk_sys) disable iff (rst)
        (new_pkt && mouse_valid && !mouse_ready) || mouse_overrun |=> mouse_overrun)
        else begin err_count++; $error("Mouse overrun not set or not held"); end

endmodule

/* test/tb_osd_ctrl.sv */
`timescale 1ns/1ns
`include "osd_defines.svh"

module tb_osd_ctrl;
    import osd_pkg::*;

    // Cycles of reset, crop, menumask, user port, mouse and overrun tests
    localparam int TEST_CYCLES = 11 + 16 * 5 + 4 * 5 + 9 * 4 + 2 * 6 + 8;
    localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;

    logic clk_sys = 1'b0;
    logic rst;
    status_t status;
    hdmi_dim_t hdmi_width, hdmi_height;
    logic force_scan2x, direct_video, rotate_en, core_vertical, game_tx, uart_tx;
    user_port_t user_in, joy_out, user_out;
    ps2_mouse_t ps2_mouse;
    logic mouse_ready;
    crop_off_t crop_off;
    crop_size_t crop_size;
    crop_scale_t crop_scale;
    menumask_t menumask;
    logic uart_rx, game_rx, db15_en, uart_en, hsize_enable, framebuf_flip;
    pos_offset_t hsize_scale, hoffset, voffset;
    logic mouse_valid, mouse_overrun;
    mouse_delta_t mouse_dx, mouse_dy;
    mouse_flags_t mouse_flags;

    logic [31:0] rng = 32'hdf798a11;
    int cycle_cnt = 0;
    int tests_run = 0;
    int tests_bad = 0;
    int errs_at_start = 0;

    osd_ctrl_top uut (.*);

    bind osd_ctrl_top osd_ctrl_assert chk (.*);

    always #4 clk_sys = ~clk_sys;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic start_test();
        errs_at_start = uut.chk.err_count;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (uut.chk.err_count != errs_at_start) begin
            tests_bad++;
            $display("%s: %0d assertion errors", name, uut.chk.err_count - errs_at_start);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic apply_video(input status_t st, input hdmi_dim_t w, input hdmi_dim_t h,
                               input logic fs, input logic dv, input logic rot);
        @(negedge clk_sys);
        status       = st;
        hdmi_width   = w;
        hdmi_height  = h;
        force_scan2x = fs;
        direct_video = dv;
        rotate_en    = rot;
    endtask

    task automatic send_mouse_packet();
        logic [31:0] r;
        @(negedge clk_sys);
        r = next_rand();
        ps2_mouse = {~ps2_mouse[24], r[23:0]};
    endtask

    // Watchdog
    always @(posedge clk_sys) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        status_t st;
        logic [31:0] r;
        rst = 1'b1;
        status = '0;
        hdmi_width = 12'd1920;
        hdmi_height = 12'd1080;
        {force_scan2x, direct_video, rotate_en, core_vertical, game_tx, uart_tx} = '0;
        user_in = '1;
        joy_out = '0;
        ps2_mouse = '0;
        mouse_ready = 1'b0;
        repeat (8) @(negedge clk_sys);
        rst = 1'b0;

        start_test();
        repeat (3) @(negedge clk_sys);
        report_test("reset");

        start_test();
        for (int i = 0; i < 16; i++) begin
            st = {next_rand(), next_rand()};
            st[`OSD_BIT_VCOPT +: 4] = 4'(i);
            st[`OSD_BIT_SCAN_FX +: 3] = 3'd0;
            st[`OSD_BIT_CROP_SCALE +: 2] = 2'd0;
            st[`OSD_BIT_CROP_EN] = (i < 8);
            case (i % 8)
                1: apply_video(st, 12'd1280, 12'd1080, 1'b0, 1'b0, 1'b0);
                2: apply_video(st, 12'd1920, 12'd720, 1'b0, 1'b0, 1'b0);
                3: apply_video(st | 64'h8, 12'd1920, 12'd1080, 1'b0, 1'b0, 1'b0);
                4: apply_video(st | (64'h1 << `OSD_BIT_CROP_SCALE), 12'd1920, 12'd1080,
                               1'b0, 1'b0, 1'b0);
                5: apply_video(st, 12'd1920, 12'd1080, 1'b1, 1'b0, 1'b0);
                6: apply_video(st, 12'd1920, 12'd1080, 1'b0, 1'b1, 1'b0);
                7: apply_video(st, 12'd1920, 12'd1080, 1'b0, 1'b0, 1'b1);
                default: apply_video(st, 12'd1920, 12'd1080, 1'b0, 1'b0, 1'b0);
            endcase
            repeat (4) @(negedge clk_sys);
        end
        report_test("crop");

        start_test();
        for (int k = 0; k < 4; k++) begin
            apply_video({next_rand(), next_rand()}, 12'd1920, 12'd1080, 1'b0, k[1], 1'b0);
            core_vertical = k[0];
            repeat (4) @(negedge clk_sys);
        end
        report_test("menumask");

        start_test();
        for (int m = 0; m < 9; m++) begin
            st = {next_rand(), next_rand()};
            st[`OSD_BIT_DB15] = (m % 3 == 0);
            st[`OSD_BIT_UART] = (m % 3 == 1);
            apply_video(st, hdmi_width, hdmi_height, 1'b0, 1'b0, 1'b0);
            r = next_rand();
            {joy_out, user_in, uart_tx, game_tx} = r[15:0];
            repeat (3) @(negedge clk_sys);
        end
        report_test("user_port");

        start_test();
        for (int p = 0; p < 2; p++) begin
            send_mouse_packet();
            while (!mouse_valid) @(negedge clk_sys);
            repeat (3) @(negedge clk_sys);
            mouse_ready = 1'b1;
            while (mouse_valid) @(negedge clk_sys);
            mouse_ready = 1'b0;
        end
        report_test("mouse");

        start_test();
        send_mouse_packet();
        while (!mouse_valid) @(negedge clk_sys);
        send_mouse_packet();
        repeat (3) @(negedge clk_sys);
        mouse_ready = 1'b1;
        while (mouse_valid) @(negedge clk_sys);
        mouse_ready = 1'b0;
        @(negedge clk_sys);
        if (!mouse_overrun) begin
            uut.chk.err_count++;
            $display("Mouse overrun flag not set after a dropped packet");
        end
        report_test("overrun");

        $display("%0d tests run, %0d with errors, %0d assertion errors in total",
                 tests_run, tests_bad, uut.chk.err_count);
        if (uut.chk.err_count == 0 && tests_bad == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+design
design/osd_pkg.sv
design/osd_cfg_if.sv
design/status_decode.sv
design/crop_calc.sv
design/mouse_decode.sv
design/user_osd_outputs.sv
design/osd_ctrl_top.sv
test/osd_ctrl_assert.sv
test/tb_osd_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_osd_ctrl
FILELIST  = tb.f
RUNFLAGS  = +verilator+error+limit+1000
PASS_MSG  = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) $(RUNFLAGS) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
